// File: verilog/i2c_pkg.sv
`default_nettype none

package i2c_pkg;

    localparam int ADDR_W = 7;   // 7-bit device address.
    localparam int BYTE_W = 8;   // register address and data byte.
    localparam int DIV_W  = 16;

    // transaction states of the controller.
    typedef enum logic [3:0] {
        S_IDLE      = 4'h0,
        S_START     = 4'h1,
        S_ADDR_W    = 4'h2,
        S_CHECK_ACK = 4'h3,
        S_REG_ADDR  = 4'h4,
        S_WR_DATA   = 4'h5,
        S_RESTART   = 4'h6,
        S_ADDR_R    = 4'h7,
        S_RD_DATA   = 4'h8,
        S_SEND_NACK = 4'h9,
        S_STOP      = 4'hA
    } txn_state_t;

    // quarter-bit phase. SCL is low in phases 3 and 0 and high in phases 1 and 2.
    typedef logic [1:0] phase_t;

endpackage

`default_nettype wire

// File: verilog/i2c_clk_div.sv
`timescale 1ns/1ns
`default_nettype none

module i2c_clk_div import i2c_pkg::*; #(
    parameter int CLK_DIV_W = DIV_W
) (
    input  logic                 i_clk,
    input  logic                 i_rst,
    input  logic [CLK_DIV_W-1:0] i_divider,
    output logic                 o_tick
);

    logic [CLK_DIV_W-1:0] cnt;

    // the compare is >= so a smaller divider loaded mid-count still wraps.
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            cnt    <= '0;
            o_tick <= 1'b0;
        end else if (cnt >= i_divider) begin
            cnt    <= '0;
            o_tick <= 1'b1;
        end else begin
            cnt    <= cnt + 1'b1;
            o_tick <= 1'b0;
        end
    end

    a_tick_spacing : assert property (@(posedge i_clk) disable iff (i_rst)
        (o_tick && i_divider != '0) |=> !o_tick);

endmodule

`default_nettype wire

// File: verilog/i2c_cmd_regs.sv
`timescale 1ns/1ns
`default_nettype none

module i2c_cmd_regs import i2c_pkg::*; #(
    parameter int CLK_DIV_W  = DIV_W,
    parameter int ADDR_WIDTH = ADDR_W
) (
    input  logic                  i_clk,
    input  logic                  i_rst,
    input  logic                  i_start,
    input  logic                  i_rw,
    input  logic [ADDR_WIDTH-1:0] i_dev_addr,
    input  logic [BYTE_W-1:0]     i_reg_addr,
    input  logic [BYTE_W-1:0]     i_wr_data,
    input  logic [CLK_DIV_W-1:0]  i_divider,
    input  logic                  i_done,
    input  logic                  i_nack,
    input  logic [BYTE_W-1:0]     i_rd_byte,
    output logic                  o_go,
    output logic                  o_rw,
    output logic [ADDR_WIDTH-1:0] o_dev_addr,
    output logic [BYTE_W-1:0]     o_reg_addr,
    output logic [BYTE_W-1:0]     o_wr_data,
    output logic [CLK_DIV_W-1:0]  o_divider,
    output logic                  o_busy,
    output logic                  o_done,
    output logic                  o_ack_err,
    output logic [BYTE_W-1:0]     o_rd_data
);

    logic accept;

    assign accept = i_start && !o_busy;   // a strobe while busy is dropped.

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_go      <= 1'b0;
            o_busy    <= 1'b0;
            o_done    <= 1'b0;
            o_ack_err <= 1'b0;
            o_divider <= '0;
        end else begin
            o_go   <= accept;
            o_done <= i_done;
            if (accept) begin
                o_busy    <= 1'b1;
                o_ack_err <= 1'b0;
                o_divider <= i_divider;
            end else if (i_done) begin
                o_busy    <= 1'b0;
                o_ack_err <= i_nack;
            end
        end
    end

    // the request stays frozen for the whole transfer.
    always_ff @(posedge i_clk) begin
        if (accept) begin
            o_rw       <= i_rw;
            o_dev_addr <= i_dev_addr;
            o_reg_addr <= i_reg_addr;
            o_wr_data  <= i_wr_data;
            o_rd_data  <= '0;
        end else if (i_done) begin
            o_rd_data <= i_rd_byte;
        end
    end

    a_done_while_busy : assert property (@(posedge i_clk) disable iff (i_rst)
        i_done |-> o_busy);

endmodule

`default_nettype wire

// File: verilog/i2c_phase_seq.sv
`timescale 1ns/1ns
`default_nettype none

module i2c_phase_seq import i2c_pkg::*; (
    input  logic   i_clk,
    input  logic   i_rst,
    input  logic   i_tick,
    input  logic   i_idle,
    input  logic   i_scl,
    output phase_t o_phase,
    output logic   o_step
);

    phase_t phase_q;
    logic   wait_q;   // a phase 1 tick came while the slave still held scl low.
    logic   due;

    assign due = i_tick || wait_q;

    // phase 1 is where the master has released scl, so it waits for the line.
    // once the slave lets go the step follows at once instead of on the next tick.
    assign o_step  = !i_idle && ((phase_q == 2'd1) ? (due && i_scl) : i_tick);
    assign o_phase = phase_q;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            phase_q <= 2'd0;
            wait_q  <= 1'b0;
        end else if (i_idle) begin
            phase_q <= 2'd0;   // every transfer starts on phase 0.
            wait_q  <= 1'b0;
        end else begin
            if (o_step) begin
                phase_q <= phase_q + 2'd1;
            end
            wait_q <= (phase_q == 2'd1) && due && !i_scl;
        end
    end

    a_stretch_hold : assert property (@(posedge i_clk) disable iff (i_rst)
        (o_phase == 2'd1 && !i_scl && !i_idle) |=> o_phase == 2'd1);

endmodule

`default_nettype wire

// File: verilog/i2c_txn_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module i2c_txn_ctrl import i2c_pkg::*; #(
    parameter int ADDR_WIDTH = ADDR_W
) (
    input  logic                  i_clk,
    input  logic                  i_rst,
    input  logic                  i_go,
    input  logic                  i_rw,
    input  logic [ADDR_WIDTH-1:0] i_dev_addr,
    input  logic [BYTE_W-1:0]     i_reg_addr,
    input  logic [BYTE_W-1:0]     i_wr_data,
    input  phase_t                i_phase,
    input  logic                  i_step,
    input  logic                  i_sda,
    output logic                  o_idle,
    output logic                  o_scl_low,
    output logic                  o_sda_low,
    output logic                  o_done,
    output logic                  o_nack,
    output logic [BYTE_W-1:0]     o_rd_byte
);

    localparam int CNT_W = $clog2(BYTE_W);

    txn_state_t        state;
    txn_state_t        ack_from;   // byte state that led into CHECK_ACK.
    logic [BYTE_W-1:0] shift;
    logic [CNT_W-1:0]  bit_cnt;
    logic              ack_ok;
    logic              last_bit;

    assign o_idle    = (state == S_IDLE);
    assign o_rd_byte = shift;
    assign last_bit  = (bit_cnt == CNT_W'(BYTE_W - 1));

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state     <= S_IDLE;
            ack_from  <= S_IDLE;
            bit_cnt   <= '0;
            o_scl_low <= 1'b0;
            o_sda_low <= 1'b0;
            o_done    <= 1'b0;
            o_nack    <= 1'b0;
        end else begin
            o_done <= 1'b0;
            o_nack <= 1'b0;
            if (state == S_IDLE) begin
                if (i_go) begin
                    shift <= BYTE_W'({i_dev_addr, 1'b0});
                    state <= S_START;
                end
            end else if (i_step) begin
                // scl rises after phase 0 and falls after phase 2 for every bit.
                if (i_phase == 2'd0) begin
                    o_scl_low <= 1'b0;
                end
                if (i_phase == 2'd2 && state != S_STOP && state != S_RESTART) begin
                    o_scl_low <= 1'b1;
                end

                case (state)
                    S_START: begin
                        if (i_phase == 2'd1) begin
                            o_sda_low <= 1'b1;   // sda falls while scl is high.
                        end
                        if (i_phase == 2'd3) begin
                            o_sda_low <= !shift[BYTE_W-1];
                            bit_cnt   <= '0;
                            // the r/w bit already in the byte tells which start this was.
                            state     <= shift[0] ? S_ADDR_R : S_ADDR_W;
                        end
                    end

                    S_ADDR_W, S_REG_ADDR, S_WR_DATA, S_ADDR_R: begin
                        if (i_phase == 2'd3) begin
                            if (last_bit) begin
                                o_sda_low <= 1'b0;   // let the slave drive the ack.
                                ack_from  <= state;
                                state     <= S_CHECK_ACK;
                            end else begin
                                o_sda_low <= !shift[BYTE_W-2];
                                shift     <= {shift[BYTE_W-2:0], 1'b0};
                                bit_cnt   <= bit_cnt + 1'b1;
                            end
                        end
                    end

                    S_CHECK_ACK: begin
                        if (i_phase == 2'd2) begin
                            ack_ok <= !i_sda;
                        end
                        if (i_phase == 2'd3) begin
                            bit_cnt <= '0;
                            if (!ack_ok) begin
                                // abort without a stop, both lines go back to released.
                                o_scl_low <= 1'b0;
                                o_sda_low <= 1'b0;
                                o_done    <= 1'b1;
                                o_nack    <= 1'b1;
                                state     <= S_IDLE;
                            end else begin
                                case (ack_from)
                                    S_ADDR_W: begin
                                        shift     <= i_reg_addr;
                                        o_sda_low <= !i_reg_addr[BYTE_W-1];
                                        state     <= S_REG_ADDR;
                                    end
                                    S_REG_ADDR: begin
                                        if (i_rw) begin
                                            state <= S_RESTART;
                                        end else begin
                                            shift     <= i_wr_data;
                                            o_sda_low <= !i_wr_data[BYTE_W-1];
                                            state     <= S_WR_DATA;
                                        end
                                    end
                                    S_WR_DATA: begin
                                        o_sda_low <= 1'b1;   // held low so the stop can raise it.
                                        state     <= S_STOP;
                                    end
                                    S_ADDR_R: state <= S_RD_DATA;
                                    default:  state <= S_IDLE;
                                endcase
                            end
                        end
                    end

                    S_RESTART: begin
                        if (i_phase == 2'd3) begin
                            shift <= BYTE_W'({i_dev_addr, 1'b1});
                            state <= S_START;
                        end
                    end

                    S_RD_DATA: begin
                        if (i_phase == 2'd2) begin
                            shift <= {shift[BYTE_W-2:0], i_sda};   // msb first.
                        end
                        if (i_phase == 2'd3) begin
                            if (last_bit) begin
                                state <= S_SEND_NACK;   // sda stays released as the nack.
                            end else begin
                                bit_cnt <= bit_cnt + 1'b1;
                            end
                        end
                    end

                    S_SEND_NACK: begin
                        if (i_phase == 2'd3) begin
                            o_sda_low <= 1'b1;
                            state     <= S_STOP;
                        end
                    end

                    S_STOP: begin
                        if (i_phase == 2'd1) begin
                            o_sda_low <= 1'b0;   // sda rises while scl is high.
                        end
                        if (i_phase == 2'd3) begin
                            o_done <= 1'b1;
                            state  <= S_IDLE;
                        end
                    end

                    default: state <= S_IDLE;
                endcase
            end
        end
    end

    // sda may only move while scl is high to form a start or a stop.
    a_sda_stable_high : assert property (@(posedge i_clk) disable iff (i_rst)
        ((i_phase == 2'd1 || i_phase == 2'd2) &&
         !(state inside {S_START, S_RESTART, S_STOP})) |=> $stable(o_sda_low));

endmodule

`default_nettype wire

// File: verilog/i2c_master_top.sv
`timescale 1ns/1ns
`default_nettype none

module i2c_master_top import i2c_pkg::*; #(
    parameter int CLK_DIV_W  = DIV_W,
    parameter int ADDR_WIDTH = ADDR_W
) (
    input  logic                  i_clk,
    input  logic                  i_rst,
    input  logic                  i_start,
    input  logic                  i_rw,
    input  logic [ADDR_WIDTH-1:0] i_dev_addr,
    input  logic [BYTE_W-1:0]     i_reg_addr,
    input  logic [BYTE_W-1:0]     i_wr_data,
    input  logic [CLK_DIV_W-1:0]  i_divider,
    input  logic                  i_scl,
    input  logic                  i_sda,
    output logic                  o_scl_oe,
    output logic                  o_sda_oe,
    output logic                  o_busy,
    output logic                  o_done,
    output logic                  o_ack_err,
    output logic [BYTE_W-1:0]     o_rd_data
);

    logic                  go;
    logic                  rw;
    logic [ADDR_WIDTH-1:0] dev_addr;
    logic [BYTE_W-1:0]     reg_addr;
    logic [BYTE_W-1:0]     wr_data;
    logic [CLK_DIV_W-1:0]  divider;
    logic                  tick;
    logic                  step;
    logic                  idle;
    phase_t                phase;
    logic                  done;
    logic                  nack;
    logic [BYTE_W-1:0]     rd_byte;

    i2c_cmd_regs #(
        .CLK_DIV_W  (CLK_DIV_W),
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_cmd_regs (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_start    (i_start),
        .i_rw       (i_rw),
        .i_dev_addr (i_dev_addr),
        .i_reg_addr (i_reg_addr),
        .i_wr_data  (i_wr_data),
        .i_divider  (i_divider),
        .i_done     (done),
        .i_nack     (nack),
        .i_rd_byte  (rd_byte),
        .o_go       (go),
        .o_rw       (rw),
        .o_dev_addr (dev_addr),
        .o_reg_addr (reg_addr),
        .o_wr_data  (wr_data),
        .o_divider  (divider),
        .o_busy     (o_busy),
        .o_done     (o_done),
        .o_ack_err  (o_ack_err),
        .o_rd_data  (o_rd_data)
    );

    i2c_clk_div #(
        .CLK_DIV_W (CLK_DIV_W)
    ) u_clk_div (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_divider (divider),
        .o_tick    (tick)
    );

    i2c_phase_seq u_phase_seq (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_tick  (tick),
        .i_idle  (idle),
        .i_scl   (i_scl),
        .o_phase (phase),
        .o_step  (step)
    );

    // the pull-low requests are the open-drain enables of the pads.
    i2c_txn_ctrl #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_txn_ctrl (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_go       (go),
        .i_rw       (rw),
        .i_dev_addr (dev_addr),
        .i_reg_addr (reg_addr),
        .i_wr_data  (wr_data),
        .i_phase    (phase),
        .i_step     (step),
        .i_sda      (i_sda),
        .o_idle     (idle),
        .o_scl_low  (o_scl_oe),
        .o_sda_low  (o_sda_oe),
        .o_done     (done),
        .o_nack     (nack),
        .o_rd_byte  (rd_byte)
    );

endmodule

`default_nettype wire

// File: tb/i2c_slave_model.sv
`timescale 1ns/1ns
`default_nettype none

module i2c_slave_model #(
    parameter logic [6:0] DEV_ADDR = 7'h2A
) (
    input  logic       i_clk,
    input  logic       i_rst,
    input  logic       i_scl,
    input  logic       i_sda,
    input  logic [7:0] i_stretch,
    output logic       o_scl_low,
    output logic       o_sda_low
);

    typedef enum logic [2:0] {SL_IDLE, SL_RX, SL_RX_ACK, SL_TX, SL_TX_ACK} slave_state_t;

    slave_state_t state;
    logic [7:0]   mem [8];
    logic [7:0]   shift;
    logic [7:0]   reg_ptr;
    logic [3:0]   bit_cnt;
    logic [1:0]   byte_idx;   // 0 device address, 1 register address, 2 data.
    logic         rw;
    logic         scl_q;
    logic         sda_q;
    logic [7:0]   stretch_left;
    logic         rise;
    logic         fall;
    logic         start_cond;
    logic         stop_cond;

    function automatic logic [7:0] initial_byte(input int idx);
        return 8'h5A ^ 8'(idx * 29);
    endfunction

    assign rise       = i_scl && !scl_q;
    assign fall       = !i_scl && scl_q;
    assign start_cond = i_scl && scl_q && sda_q && !i_sda;
    assign stop_cond  = i_scl && scl_q && !sda_q && i_sda;
    assign o_scl_low  = (stretch_left != 8'd0);   // scl is held low after each falling edge.

    always @(posedge i_clk) begin
        scl_q <= i_scl;
        sda_q <= i_sda;
        if (i_rst) begin
            state        <= SL_IDLE;
            o_sda_low    <= 1'b0;
            stretch_left <= '0;
            bit_cnt      <= '0;
            byte_idx     <= '0;
            rw           <= 1'b0;
            reg_ptr      <= '0;
            shift        <= '0;
            for (int i = 0; i < 8; i++) begin
                mem[i] <= initial_byte(i);
            end
        end else begin
            if (fall) begin
                stretch_left <= i_stretch;
            end else if (stretch_left != 8'd0) begin
                stretch_left <= stretch_left - 8'd1;
            end
            if (start_cond) begin
                // an aborted transfer sends no stop, so every start begins afresh.
                state     <= SL_RX;
                bit_cnt   <= '0;
                byte_idx  <= '0;
                o_sda_low <= 1'b0;
            end else if (stop_cond) begin
                state     <= SL_IDLE;
                o_sda_low <= 1'b0;
            end else if (rise) begin
                if (state == SL_RX) begin
                    shift <= {shift[6:0], i_sda};
                end
                if (state == SL_RX || state == SL_TX) begin
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end else if (fall) begin
                case (state)
                    SL_RX: begin
                        if (bit_cnt == 4'd8) begin
                            bit_cnt <= '0;
                            if (byte_idx == 2'd0 && shift[7:1] != DEV_ADDR) begin
                                state <= SL_IDLE;   // not ours, sda stays released.
                            end else begin
                                o_sda_low <= 1'b1;
                                state     <= SL_RX_ACK;
                                if (byte_idx == 2'd0) rw <= shift[0];
                                if (byte_idx == 2'd1) reg_ptr <= shift;
                                if (byte_idx == 2'd2) mem[reg_ptr[2:0]] <= shift;
                            end
                        end
                    end
                    SL_RX_ACK: begin
                        byte_idx <= byte_idx + 2'd1;
                        if (byte_idx == 2'd0 && rw) begin
                            shift     <= mem[reg_ptr[2:0]];
                            o_sda_low <= !mem[reg_ptr[2:0]][7];
                            state     <= SL_TX;
                        end else begin
                            o_sda_low <= 1'b0;
                            state     <= SL_RX;
                        end
                    end
                    SL_TX: begin
                        if (bit_cnt == 4'd8) begin
                            o_sda_low <= 1'b0;   // the master answers with its nack.
                            state     <= SL_TX_ACK;
                        end else begin
                            o_sda_low <= !shift[6];
                            shift     <= {shift[6:0], 1'b0};
                        end
                    end
                    SL_TX_ACK: state <= SL_IDLE;
                    default: ;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: tb/i2c_checker.sv
`timescale 1ns/1ns
`default_nettype none

module i2c_checker #(
    parameter logic [6:0] SLAVE_ADDR = 7'h2A
) (
    input  logic       i_clk,
    input  logic       i_rst,
    input  logic       i_start,
    input  logic       i_rw,
    input  logic [6:0] i_dev_addr,
    input  logic [7:0] i_reg_addr,
    input  logic [7:0] i_wr_data,
    input  logic       i_busy,
    input  logic       i_done,
    input  logic       i_ack_err,
    input  logic [7:0] i_rd_data,
    input  logic       i_scl_oe,
    input  logic       i_sda_oe,
    output int         o_errors,
    output int         o_checks
);

    logic [7:0] shadow [8];
    logic       rst_d;
    logic       pending;
    logic       req_rw;
    logic [6:0] req_dev;
    logic [7:0] req_reg;
    logic [7:0] req_data;
    logic [8:0] expected;
    int         errors = 0;
    int         checks = 0;

    assign o_errors = errors;
    assign o_checks = checks;

    function automatic logic [7:0] initial_byte(input int idx);
        return 8'h5A ^ 8'(idx * 29);
    endfunction

    // {ack error, read byte}. a write has no read byte to compare.
    function automatic logic [8:0] expect_result(input logic rw, input logic [6:0] dev,
                                                 input logic [7:0] reg_a);
        if (dev != SLAVE_ADDR) begin
            return {1'b1, 8'h00};
        end
        return {1'b0, rw ? shadow[reg_a[2:0]] : 8'h00};
    endfunction

    task automatic compare(input string name, input int exp, input int act);
        checks++;
        if (exp != act) begin
            errors++;
            $display("ERROR t=%0t %s expected %0h actual %0h", $time, name, exp, act);
        end
    endtask

    always @(posedge i_clk) begin
        rst_d <= i_rst;
        if (rst_d) begin
            compare("o_busy", 0, i_busy);
            compare("o_done", 0, i_done);
            compare("o_ack_err", 0, i_ack_err);
            compare("o_scl_oe", 0, i_scl_oe);
            compare("o_sda_oe", 0, i_sda_oe);
        end
        if (i_rst) begin
            pending <= 1'b0;
            for (int i = 0; i < 8; i++) begin
                shadow[i] <= initial_byte(i);
            end
        end else begin
            if (pending && !i_done) begin
                compare("o_busy", 1, i_busy);   // busy covers the whole open request.
            end
            if (i_done) begin
                if (!pending) begin
                    errors++;
                    $display("o_done pulsed at t=%0t with no accepted request open", $time);
                end else begin
                    expected = expect_result(req_rw, req_dev, req_reg);
                    compare("o_busy", 0, i_busy);
                    compare("o_ack_err", expected[8], i_ack_err);
                    if (req_rw && !expected[8]) begin
                        compare("o_rd_data", expected[7:0], i_rd_data);
                    end
                    if (!req_rw && !expected[8]) begin
                        shadow[req_reg[2:0]] <= req_data;
                    end
                end
                pending <= 1'b0;
            end
            if (i_start && (!pending || i_done)) begin   // a strobe while busy is not a request.
                pending  <= 1'b1;
                req_rw   <= i_rw;
                req_dev  <= i_dev_addr;
                req_reg  <= i_reg_addr;
                req_data <= i_wr_data;
            end
        end
    end

endmodule

`default_nettype wire

// File: tb/tb_i2c_master.sv
`timescale 1ns/1ns
`default_nettype none

module tb_i2c_master;

    localparam logic [6:0] SLAVE_ADDR  = 7'h2A;
    localparam int         MAX_DIV     = 6;
    localparam int         MAX_STRETCH = 20;
    // 40 transfers of up to 40 bits, 4 steps a bit, doubled for margin.
    localparam int         LIMIT = 40 * 40 * 4 * (MAX_DIV + 1 + MAX_STRETCH) * 2;

    logic        i_clk;
    logic        i_rst;
    logic        i_start;
    logic        i_rw;
    logic [6:0]  i_dev_addr;
    logic [7:0]  i_reg_addr;
    logic [7:0]  i_wr_data;
    logic [15:0] i_divider;
    logic [7:0]  stretch;
    logic        scl;
    logic        sda;
    logic        scl_oe;
    logic        sda_oe;
    logic        slave_scl_low;
    logic        slave_sda_low;
    logic        busy;
    logic        done;
    logic        ack_err;
    logic [7:0]  rd_data;
    int          errors;
    int          checks;
    int          cycles = 0;
    int          failed_tests = 0;
    int          err_base = 0;
    logic [7:0]  addrs [8];
    logic [7:0]  vals  [8];
    logic [7:0]  addr;
    logic [7:0]  data;
    logic [6:0]  bad_addr;

    // wired-AND bus. a line is high unless somebody pulls it low.
    assign scl = !(scl_oe || slave_scl_low);
    assign sda = !(sda_oe || slave_sda_low);

    initial i_clk = 1'b0;
    always #10 i_clk = ~i_clk;

    i2c_master_top #(.CLK_DIV_W(16), .ADDR_WIDTH(7)) dut0 (
        .i_clk(i_clk), .i_rst(i_rst), .i_start(i_start), .i_rw(i_rw),
        .i_dev_addr(i_dev_addr), .i_reg_addr(i_reg_addr), .i_wr_data(i_wr_data),
        .i_divider(i_divider), .i_scl(scl), .i_sda(sda), .o_scl_oe(scl_oe),
        .o_sda_oe(sda_oe), .o_busy(busy), .o_done(done), .o_ack_err(ack_err),
        .o_rd_data(rd_data)
    );

    i2c_slave_model #(.DEV_ADDR(SLAVE_ADDR)) u_slave (
        .i_clk(i_clk), .i_rst(i_rst), .i_scl(scl), .i_sda(sda), .i_stretch(stretch),
        .o_scl_low(slave_scl_low), .o_sda_low(slave_sda_low)
    );

    i2c_checker #(.SLAVE_ADDR(SLAVE_ADDR)) u_checker (
        .i_clk(i_clk), .i_rst(i_rst), .i_start(i_start), .i_rw(i_rw),
        .i_dev_addr(i_dev_addr), .i_reg_addr(i_reg_addr), .i_wr_data(i_wr_data),
        .i_busy(busy), .i_done(done), .i_ack_err(ack_err), .i_rd_data(rd_data),
        .i_scl_oe(scl_oe), .i_sda_oe(sda_oe), .o_errors(errors), .o_checks(checks)
    );

    task automatic run_txn(input logic rw, input logic [6:0] dev, input logic [7:0] reg_a,
                           input logic [7:0] wdata, input logic [15:0] div,
                           input logic [7:0] str);
        @(posedge i_clk);
        i_rw       <= rw;
        i_dev_addr <= dev;
        i_reg_addr <= reg_a;
        i_wr_data  <= wdata;
        i_divider  <= div;
        stretch    <= str;
        i_start    <= 1'b1;
        @(posedge i_clk);
        i_start <= 1'b0;
        while (!done) @(posedge i_clk);
    endtask

    // a second strobe lands while the first write is still on the bus.
    task automatic overlapped_start(input logic [7:0] reg_a, input logic [7:0] wdata);
        @(posedge i_clk);
        i_rw       <= 1'b0;
        i_dev_addr <= SLAVE_ADDR;
        i_reg_addr <= reg_a;
        i_wr_data  <= wdata;
        i_divider  <= 16'd2;
        stretch    <= 8'd0;
        i_start    <= 1'b1;
        @(posedge i_clk);
        i_start <= 1'b0;
        repeat (3) @(posedge i_clk);
        i_wr_data <= ~wdata;
        i_start   <= 1'b1;
        @(posedge i_clk);
        i_start <= 1'b0;
        while (!done) @(posedge i_clk);
        repeat (600) @(posedge i_clk);   // long enough for a stray second transfer to finish.
    endtask

    task automatic finish_test(input int num, input string name);
        @(negedge i_clk);
        if (errors == err_base) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            $display("test %0d %s: %0d errors", num, name, errors - err_base);
            failed_tests++;
        end
        err_base = errors;
    endtask

    initial begin : watchdog
        while (cycles < LIMIT) begin
            @(posedge i_clk);
            cycles++;
        end
        $display("timeout after %0d cycles, a transfer never completed", cycles);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin : stimulus
        void'($urandom(32'h827e0597));
        i_rst      = 1'b1;
        i_start    = 1'b0;
        i_rw       = 1'b0;
        i_dev_addr = '0;
        i_reg_addr = '0;
        i_wr_data  = '0;
        i_divider  = 16'd2;
        stretch    = '0;
        repeat (3) @(posedge i_clk);
        i_rst <= 1'b0;
        repeat (2) @(posedge i_clk);
        finish_test(1, "reset values");

        for (int i = 0; i < 8; i++) begin
            addrs[i] = 8'($urandom);
            vals[i]  = 8'($urandom);
            run_txn(1'b0, SLAVE_ADDR, addrs[i], vals[i], 16'd2, 8'd0);
        end
        for (int i = 0; i < 8; i++) begin
            run_txn(1'b1, SLAVE_ADDR, addrs[i], 8'h00, 16'd2, 8'd0);
        end
        finish_test(2, "write then read back");

        bad_addr = SLAVE_ADDR ^ 7'($urandom_range(1, 127));
        run_txn(1'b0, bad_addr, addrs[0], ~vals[0], 16'd2, 8'd0);
        run_txn(1'b1, bad_addr, addrs[1], 8'h00, 16'd2, 8'd0);
        run_txn(1'b1, SLAVE_ADDR, addrs[0], 8'h00, 16'd2, 8'd0);
        finish_test(3, "wrong device address");

        for (int i = 0; i < 4; i++) begin
            addr = 8'($urandom);
            data = 8'($urandom);
            run_txn(1'b0, SLAVE_ADDR, addr, data, 16'd2, 8'($urandom_range(0, MAX_STRETCH)));
            run_txn(1'b1, SLAVE_ADDR, addr, 8'h00, 16'd2, 8'($urandom_range(0, MAX_STRETCH)));
        end
        finish_test(4, "clock stretching");

        addr = 8'($urandom);
        overlapped_start(addr, 8'($urandom));
        run_txn(1'b1, SLAVE_ADDR, addr, 8'h00, 16'd2, 8'd0);
        finish_test(5, "start while busy");

        for (int i = 0; i < 12; i++) begin
            run_txn(1'($urandom_range(0, 1)), SLAVE_ADDR, 8'($urandom), 8'($urandom),
                    16'($urandom_range(1, MAX_DIV)), 8'd0);
        end
        finish_test(6, "random dividers");

        $display("tests 6, failed %0d, checks %0d, errors %0d", failed_tests, checks, errors);
        if (errors == 0 && failed_tests == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
verilog/i2c_pkg.sv
verilog/i2c_clk_div.sv
verilog/i2c_cmd_regs.sv
verilog/i2c_phase_seq.sv
verilog/i2c_txn_ctrl.sv
verilog/i2c_master_top.sv
tb/i2c_slave_model.sv
tb/i2c_checker.sv
tb/tb_i2c_master.sv

// File: run_sim.sh
#!/bin/sh
# build and run the I2C master testbench with Verilator, then scan the log.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_i2c_master \
    -f project.f -o sim_tb \
    && ./obj_dir/sim_tb > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "SOME TESTS FAILED" sim.log && { echo "simulation failed"; exit 1; } \
    || { echo "simulation passed"; exit 0; }
